//--- source/soccer_pkg.sv
/*
 * Shared types and constants for the soccer video overlay.
 * Holds the pixel type, the scene colours, the pitch and scoreboard
 * geometry, the match timing and the match state encoding.
 * Modules refer to these by scoped names.
 */

package soccer_pkg;

    // ======================================================================
    // pixel and state types
    // ======================================================================

    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    typedef enum logic [1:0] {
        MATCH_KICKOFF = 2'd0,
        MATCH_PLAY    = 2'd1,
        MATCH_GOAL    = 2'd2
    } match_state_t;

    // width of every raster and ball coordinate
    localparam int COORD_W = 12;

    // ======================================================================
    // colours
    // ======================================================================
    localparam rgb_t SKY_BG     = 24'h070A12;
    localparam rgb_t GRASS_A    = 24'h0A5C1F;
    localparam rgb_t GRASS_B    = 24'h0D6A26;
    localparam rgb_t LINE_WHITE = 24'hF5F7FF;
    localparam rgb_t BALL_WHITE = 24'hF7F7F7;
    localparam rgb_t SCORE_BG   = 24'h0E1016;
    localparam rgb_t SCORE_FG   = 24'hECEFF4;

    // ======================================================================
    // geometry
    // ======================================================================
    localparam int PITCH_MARGIN = 16;
    localparam int BALL_R       = 4;
    // goal mouth spans centre line +/- this many lines
    localparam int GOAL_HALF    = 12;
    // grass stripe width is 2**STRIPE_SHIFT columns
    localparam int STRIPE_SHIFT = 3;
    localparam int DIGIT_SCALE  = 2;
    localparam int SB_LEFT      = 8;
    localparam int SB_GAP       = 3;

    // match timing, in frames
    localparam int SERVE_SPEED    = 2;
    localparam int KICKOFF_FRAMES = 4;
    localparam int GOAL_FRAMES    = 8;

endpackage

//--- source/raster_if.sv
/*
 * Decoded raster position, from the timing recovery to the match
 * logic and the renderer. x and y name the pixel on the video input
 * in the same cycle; frame_tick marks pixel (0,0).
 */

`timescale 1ns/1ps

interface raster_if;

    logic                           de;
    logic [soccer_pkg::COORD_W-1:0] x;
    logic [soccer_pkg::COORD_W-1:0] y;
    logic                           frame_tick;

    // timing recovery side
    modport source (
        output de,
        output x,
        output y,
        output frame_tick
    );

    // consumers of the position
    modport sink (
        input de,
        input x,
        input y,
        input frame_tick
    );

endinterface

//--- source/match_if.sv
/*
 * Match state seen by the renderer: ball centre and both scores.
 * Driven by the match logic, updated once per frame.
 * Scores are plain binary, 0 to 9.
 */

`timescale 1ns/1ps

interface match_if;

    logic [soccer_pkg::COORD_W-1:0] ball_x;
    logic [soccer_pkg::COORD_W-1:0] ball_y;
    logic [3:0]                     score_a;
    logic [3:0]                     score_b;

    // match logic side
    modport game (
        output ball_x,
        output ball_y,
        output score_a,
        output score_b
    );

    // renderer side
    modport view (
        input ball_x,
        input ball_y,
        input score_a,
        input score_b
    );

endinterface

//--- source/raster_timing.sv
/*
 * Raster recovery from data-enable alone. Column restarts on each DE
 * rise, line advances per active line, and frame_tick is raised on the
 * first rise of a new frame. Position is combinational, so it lines up
 * with the pixel on the input in the same cycle.
 */

`timescale 1ns/1ps

module raster_timing #(
    parameter int H_ACTIVE = 1920,
    parameter int V_ACTIVE = 1080
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     cen_i,
    input  logic     de_i,
    raster_if.source raster
);

    localparam int CW = soccer_pkg::COORD_W;
    localparam logic [CW-1:0] X_LAST = CW'(H_ACTIVE - 1);
    localparam logic [CW-1:0] Y_LAST = CW'(V_ACTIVE - 1);

    logic          de_q;
    logic          seen_line_q;
    logic          wrap_q;
    logic [CW-1:0] h_cnt_q;
    logic [CW-1:0] v_cnt_q;

    logic          de_rise;
    logic          de_fall;
    logic          new_frame;
    logic [CW-1:0] x_now;
    logic [CW-1:0] y_now;

    assign de_rise   = de_i & ~de_q;
    assign de_fall   = ~de_i & de_q;
    // first line after reset, or first line after the last one
    assign new_frame = de_rise & (~seen_line_q | wrap_q);

    // counters hold the last presented pixel, step from there
    always_comb begin
        x_now = h_cnt_q;
        y_now = v_cnt_q;
        if (de_rise) begin
            x_now = '0;
            if (new_frame) begin
                y_now = '0;
            end else if (v_cnt_q != Y_LAST) begin
                y_now = v_cnt_q + 1'b1;
            end
        end else if (h_cnt_q != X_LAST) begin
            x_now = h_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            de_q        <= 1'b0;
            seen_line_q <= 1'b0;
            wrap_q      <= 1'b0;
            h_cnt_q     <= '0;
            v_cnt_q     <= '0;
        end else if (cen_i) begin
            de_q <= de_i;
            if (de_i) begin
                h_cnt_q <= x_now;
            end
            if (de_rise) begin
                v_cnt_q     <= y_now;
                seen_line_q <= 1'b1;
                wrap_q      <= 1'b0;
            end else if (de_fall && seen_line_q && (v_cnt_q == Y_LAST)) begin
                // last active line done, next rise opens a frame
                wrap_q <= 1'b1;
            end
        end
    end

    assign raster.de         = de_i;
    assign raster.x          = x_now;
    assign raster.y          = y_now;
    assign raster.frame_tick = new_frame;

endmodule

//--- source/ball_match.sv
/*
 * Match logic, stepped once per frame_tick. Kickoff pause, then the
 * ball is served from the centre spot along the halfway row and
 * travels until it reaches a goal mouth. Each goal scores, pauses,
 * recentres the ball and flips the next serve. Scores stop at 9.
 */

`timescale 1ns/1ps

module ball_match #(
    parameter int H_ACTIVE = 1920,
    parameter int V_ACTIVE = 1080
) (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   cen_i,
    raster_if.sink raster,
    match_if.game  game
);

    localparam int CW      = soccer_pkg::COORD_W;
    localparam int PITCH_L = soccer_pkg::PITCH_MARGIN;
    localparam int PITCH_R = H_ACTIVE - soccer_pkg::PITCH_MARGIN - 1;

    localparam logic [CW-1:0] CENTRE_X = CW'(H_ACTIVE / 2);
    localparam logic [CW-1:0] CENTRE_Y = CW'(V_ACTIVE / 2);
    // ball centre positions where its edge meets the end lines
    localparam logic [CW-1:0] STOP_L   = CW'(PITCH_L + soccer_pkg::BALL_R);
    localparam logic [CW-1:0] STOP_R   = CW'(PITCH_R - soccer_pkg::BALL_R);
    localparam logic [CW-1:0] STEP     = CW'(soccer_pkg::SERVE_SPEED);
    localparam logic [3:0]    KICK_END = 4'(soccer_pkg::KICKOFF_FRAMES - 1);
    localparam logic [3:0]    GOAL_END = 4'(soccer_pkg::GOAL_FRAMES - 1);

    soccer_pkg::match_state_t state_q;
    logic [3:0]    pause_q;
    logic          serve_right_q;
    logic [CW-1:0] ball_x_q;
    logic [3:0]    score_a_q;
    logic [3:0]    score_b_q;

    logic [CW-1:0] next_x;
    logic          at_right;
    logic          at_left;

    assign next_x   = serve_right_q ? ball_x_q + STEP : ball_x_q - STEP;
    assign at_right = serve_right_q && (next_x >= STOP_R);
    assign at_left  = !serve_right_q && (next_x <= STOP_L);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= soccer_pkg::MATCH_KICKOFF;
            pause_q       <= '0;
            serve_right_q <= 1'b1;
            ball_x_q      <= CENTRE_X;
            score_a_q     <= '0;
            score_b_q     <= '0;
        end else if (cen_i && raster.frame_tick) begin
            case (state_q)
                soccer_pkg::MATCH_KICKOFF: begin
                    if (pause_q == KICK_END) begin
                        // serve leaves the spot on the last pause frame
                        pause_q  <= '0;
                        ball_x_q <= next_x;
                        state_q  <= soccer_pkg::MATCH_PLAY;
                    end else begin
                        pause_q <= pause_q + 1'b1;
                    end
                end
                soccer_pkg::MATCH_PLAY: begin
                    ball_x_q <= next_x;
                    // the centre row always lies inside the goal mouth
                    if (at_right || at_left) begin
                        if (at_right && (score_a_q != 4'd9)) begin
                            score_a_q <= score_a_q + 1'b1;
                        end
                        if (at_left && (score_b_q != 4'd9)) begin
                            score_b_q <= score_b_q + 1'b1;
                        end
                        serve_right_q <= ~serve_right_q;
                        state_q       <= soccer_pkg::MATCH_GOAL;
                    end
                end
                soccer_pkg::MATCH_GOAL: begin
                    if (pause_q == GOAL_END) begin
                        pause_q  <= '0;
                        ball_x_q <= CENTRE_X;
                        state_q  <= soccer_pkg::MATCH_KICKOFF;
                    end else begin
                        pause_q <= pause_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= soccer_pkg::MATCH_KICKOFF;
                end
            endcase
        end
    end

    assign game.ball_x  = ball_x_q;
    // no vertical motion, the ball rides the centre row
    assign game.ball_y  = CENTRE_Y;
    assign game.score_a = score_a_q;
    assign game.score_b = score_b_q;

endmodule

//--- source/pitch_render.sv
/*
 * Scene compositor and output stage. Builds the overlay colour for the
 * current raster position: sky, striped pitch with lines, ball, and a
 * scoreboard with two scaled 3x5 digits. The output register passes
 * the input through when the overlay is off or outside data-enable.
 */

`timescale 1ns/1ps

module pitch_render #(
    parameter int H_ACTIVE = 1920,
    parameter int V_ACTIVE = 1080
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             cen_i,
    input  logic             vid_sel_i,
    input  soccer_pkg::rgb_t vid_rgb_i,
    input  logic [2:0]       dvh_sync_i,
    raster_if.sink           raster,
    match_if.view            view,
    output soccer_pkg::rgb_t vid_rgb_o,
    output logic [2:0]       dvh_sync_o
);

    // ======================================================================
    // geometry
    // ======================================================================
    localparam int S       = soccer_pkg::DIGIT_SCALE;
    localparam int PITCH_L = soccer_pkg::PITCH_MARGIN;
    localparam int PITCH_R = H_ACTIVE - soccer_pkg::PITCH_MARGIN - 1;
    localparam int PITCH_T = soccer_pkg::PITCH_MARGIN;
    localparam int PITCH_B = V_ACTIVE - soccer_pkg::PITCH_MARGIN - 1;
    localparam int HALF_X  = H_ACTIVE / 2;
    localparam int BALL_R2 = soccer_pkg::BALL_R * soccer_pkg::BALL_R;

    // scoreboard box, right and bottom bounds exclusive
    localparam int SB_TOP   = PITCH_B + 1 + soccer_pkg::SB_GAP;
    localparam int SB_BOT   = SB_TOP + 5 * S + 2;
    localparam int SB_RIGHT = soccer_pkg::SB_LEFT + 26;
    localparam int DIG_Y    = SB_TOP + 1;
    localparam int DIG_A_X  = soccer_pkg::SB_LEFT + 4;
    localparam int DIG_B_X  = soccer_pkg::SB_LEFT + 16;

    // ======================================================================
    // digit glyphs
    // ======================================================================

    // five rows of three bits, top row in the high bits
    function automatic logic [14:0] glyph(input logic [3:0] d);
        case (d)
            4'd0:    glyph = 15'b111_101_101_101_111;
            4'd1:    glyph = 15'b010_110_010_010_111;
            4'd2:    glyph = 15'b111_001_111_100_111;
            4'd3:    glyph = 15'b111_001_111_001_111;
            4'd4:    glyph = 15'b101_101_111_001_001;
            4'd5:    glyph = 15'b111_100_111_001_111;
            4'd6:    glyph = 15'b111_100_111_101_111;
            4'd7:    glyph = 15'b111_001_001_001_001;
            4'd8:    glyph = 15'b111_101_111_101_111;
            4'd9:    glyph = 15'b111_101_111_001_111;
            default: glyph = 15'b000_000_000_000_000;
        endcase
    endfunction

    function automatic logic digit_on(input int px, input int py, input int x0,
                                      input int y0, input logic [3:0] d);
        logic [14:0] bits;
        int          col;
        int          row;
        bits     = glyph(d);
        digit_on = 1'b0;
        if ((px >= x0) && (px < x0 + 3 * S) && (py >= y0) && (py < y0 + 5 * S)) begin
            col      = (px - x0) / S;
            row      = (py - y0) / S;
            digit_on = bits[(4 - row) * 3 + (2 - col)];
        end
    endfunction

    // ======================================================================
    // scene colour, lowest priority first
    // ======================================================================
    int               px;
    int               py;
    int               dx;
    int               dy;
    logic             in_pitch;
    logic             on_line;
    logic             in_board;
    soccer_pkg::rgb_t scene;

    always_comb begin
        px = int'(raster.x);
        py = int'(raster.y);
        dx = px - int'(view.ball_x);
        dy = py - int'(view.ball_y);

        in_pitch = (px >= PITCH_L) && (px <= PITCH_R) && (py >= PITCH_T) && (py <= PITCH_B);
        // two-pixel outline plus the two halfway columns
        on_line  = (px <= PITCH_L + 1) || (px >= PITCH_R - 1) ||
                   (py <= PITCH_T + 1) || (py >= PITCH_B - 1) ||
                   (px == HALF_X - 1) || (px == HALF_X);
        in_board = (px >= soccer_pkg::SB_LEFT) && (px < SB_RIGHT) &&
                   (py >= SB_TOP) && (py < SB_BOT);

        scene = soccer_pkg::SKY_BG;
        if (in_pitch) begin
            scene = raster.x[soccer_pkg::STRIPE_SHIFT] ? soccer_pkg::GRASS_B
                                                       : soccer_pkg::GRASS_A;
            if (on_line) begin
                scene = soccer_pkg::LINE_WHITE;
            end
        end
        if (dx * dx + dy * dy <= BALL_R2) begin
            scene = soccer_pkg::BALL_WHITE;
        end
        if (in_board) begin
            scene = soccer_pkg::SCORE_BG;
            if (digit_on(px, py, DIG_A_X, DIG_Y, view.score_a) ||
                digit_on(px, py, DIG_B_X, DIG_Y, view.score_b)) begin
                scene = soccer_pkg::SCORE_FG;
            end
        end
    end

    // ======================================================================
    // output stage, one enabled cycle
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vid_rgb_o  <= soccer_pkg::SKY_BG;
            dvh_sync_o <= 3'b000;
        end else if (cen_i) begin
            vid_rgb_o  <= (vid_sel_i && raster.de) ? scene : vid_rgb_i;
            dvh_sync_o <= dvh_sync_i;
        end
    end

endmodule

//--- source/soccer_overlay.sv
/*
 * Top level of the soccer overlay. Plain video ports in and out with
 * one enabled cycle of latency. vid_sel_i picks the rendered match
 * over the live input. dvh_sync_i is {de, vsync, hsync}.
 */

`timescale 1ns/1ps

module soccer_overlay #(
    parameter int H_ACTIVE = 1920,
    parameter int V_ACTIVE = 1080
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             cen_i,
    input  logic             vid_sel_i,
    input  soccer_pkg::rgb_t vid_rgb_i,
    // {vblank, hblank}, raster comes from DE edges instead
    input  logic [1:0]       vh_blank_i,
    input  logic [2:0]       dvh_sync_i,
    output logic [2:0]       dvh_sync_o,
    output soccer_pkg::rgb_t vid_rgb_o
);

    raster_if u_raster ();
    match_if  u_match ();

    raster_timing #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_raster_timing (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .cen_i  (cen_i),
        .de_i   (dvh_sync_i[2]),
        .raster (u_raster)
    );

    ball_match #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_ball_match (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .cen_i  (cen_i),
        .raster (u_raster),
        .game   (u_match)
    );

    pitch_render #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_pitch_render (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cen_i      (cen_i),
        .vid_sel_i  (vid_sel_i),
        .vid_rgb_i  (vid_rgb_i),
        .dvh_sync_i (dvh_sync_i),
        .raster     (u_raster),
        .view       (u_match),
        .vid_rgb_o  (vid_rgb_o),
        .dvh_sync_o (dvh_sync_o)
    );

endmodule

//--- test/video_source.sv
/*
 * Testbench raster generator. Walks a small frame with blanking and
 * active-high syncs, and advances only on enabled cycles. Presents the
 * raster position of each pixel next to it, so the testbench knows which
 * pixel the DUT is looking at. Pixel data is random with a fixed seed.
 */

`timescale 1ns/1ps

module video_source #(
    parameter int H_ACTIVE = 128,
    parameter int V_ACTIVE = 96,
    parameter int H_TOTAL  = 160,
    parameter int V_TOTAL  = 104
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           cen_i,
    output soccer_pkg::rgb_t               rgb_o,
    output logic [2:0]                     dvh_sync_o,
    output logic [1:0]                     vh_blank_o,
    output logic [soccer_pkg::COORD_W-1:0] x_o,
    output logic [soccer_pkg::COORD_W-1:0] y_o
);

    localparam int CW       = soccer_pkg::COORD_W;
    localparam int HS_START = H_ACTIVE + 8;
    localparam int HS_END   = HS_START + 16;
    localparam int VS_START = V_ACTIVE + 2;
    localparam int VS_END   = VS_START + 2;

    integer           seed    = 32'h4d53;
    int               h_cnt   = 0;
    int               v_cnt   = 0;
    soccer_pkg::rgb_t rgb_q   = '0;
    logic [2:0]       sync_q  = '0;
    logic [1:0]       blank_q = '0;
    logic [CW-1:0]    x_q     = '0;
    logic [CW-1:0]    y_q     = '0;

    logic de;
    logic hsync;
    logic vsync;

    assign de    = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign hsync = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign vsync = (v_cnt >= VS_START) && (v_cnt < VS_END);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            h_cnt   <= 0;
            v_cnt   <= 0;
            rgb_q   <= '0;
            sync_q  <= '0;
            blank_q <= '0;
            x_q     <= '0;
            y_q     <= '0;
        end else if (cen_i) begin
            rgb_q   <= 24'($random(seed));
            sync_q  <= {de, vsync, hsync};
            blank_q <= {v_cnt >= V_ACTIVE, h_cnt >= H_ACTIVE};
            x_q     <= CW'(h_cnt);
            y_q     <= CW'(v_cnt);
            if (h_cnt == H_TOTAL - 1) begin
                h_cnt <= 0;
                v_cnt <= (v_cnt == V_TOTAL - 1) ? 0 : v_cnt + 1;
            end else begin
                h_cnt <= h_cnt + 1;
            end
        end
    end

    assign rgb_o      = rgb_q;
    assign dvh_sync_o = sync_q;
    assign vh_blank_o = blank_q;
    assign x_o        = x_q;
    assign y_o        = y_q;

endmodule

//--- test/tb_soccer_overlay.sv
/*
 * Testbench for the soccer overlay on a 128x96 active raster.
 * Two frames of passthrough, then the overlay runs until both score
 * digits have changed. Short enable gaps are spread over the run.
 * Concurrent assertions compare the output with the previous enabled
 * input and with the expected scene colours at probe pixels.
 */

`timescale 1ns/1ps

module tb_soccer_overlay;

    localparam int H_ACTIVE     = 128;
    localparam int V_ACTIVE     = 96;
    localparam int H_TOTAL      = 160;
    localparam int V_TOTAL      = 104;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int PM           = soccer_pkg::PITCH_MARGIN;

    // frames from the centre spot to either goal, then two full goals plus margin
    localparam int TRAVEL_FRAMES = (H_ACTIVE / 2 - PM) / soccer_pkg::SERVE_SPEED;
    localparam int LIMIT_FRAMES  = 2 * (soccer_pkg::KICKOFF_FRAMES + TRAVEL_FRAMES) +
                                   soccer_pkg::GOAL_FRAMES + 8;
    localparam int LIMIT_CYCLES  = LIMIT_FRAMES * FRAME_CYCLES;

    // probes on the centre cell of each digit, one border row above the digits
    localparam int SB_TOP    = V_ACTIVE - PM + soccer_pkg::SB_GAP;
    localparam int PROBE_Y   = SB_TOP + 1 + 2 * soccer_pkg::DIGIT_SCALE;
    localparam int PROBE_A_X = soccer_pkg::SB_LEFT + 4 + soccer_pkg::DIGIT_SCALE;
    localparam int PROBE_B_X = soccer_pkg::SB_LEFT + 16 + soccer_pkg::DIGIT_SCALE;
    // centre cell of glyph 0 is dark, of glyph 1 lit
    localparam bit ZERO_MID = 1'b0;
    localparam bit ONE_MID  = 1'b1;
    localparam soccer_pkg::rgb_t ZERO_RGB = ZERO_MID ? soccer_pkg::SCORE_FG : soccer_pkg::SCORE_BG;
    localparam soccer_pkg::rgb_t ONE_RGB  = ONE_MID ? soccer_pkg::SCORE_FG : soccer_pkg::SCORE_BG;

    logic clk_i = 1'b0;
    logic rst_i;
    logic cen_i = 1'b1;
    logic vid_sel_i;
    soccer_pkg::rgb_t src_rgb;
    soccer_pkg::rgb_t vid_rgb_o;
    logic [2:0] src_sync;
    logic [2:0] dvh_sync_o;
    logic [1:0] src_blank;
    logic [soccer_pkg::COORD_W-1:0] src_x;
    logic [soccer_pkg::COORD_W-1:0] src_y;

    // input of the previous enabled cycle, and what has been seen so far
    soccer_pkg::rgb_t rgb_q;
    logic [2:0] sync_q;
    logic sel_q;
    int x_q;
    int y_q;
    int cycle_cnt = 0;
    logic a_seen = 1'b0;
    logic a_lit = 1'b0;
    logic b_lit = 1'b0;
    int line0_hits = 0;
    int outline_hits = 0;
    int hold_hits = 0;
    int pass_hits = 0;

    logic on_video;
    logic at_a;
    logic at_b;
    logic on_outline;

    initial begin
        forever #50 clk_i = ~clk_i;
    end

    video_source #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_TOTAL  (V_TOTAL)
    ) u_video_source (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cen_i      (cen_i),
        .rgb_o      (src_rgb),
        .dvh_sync_o (src_sync),
        .vh_blank_o (src_blank),
        .x_o        (src_x),
        .y_o        (src_y)
    );

    soccer_overlay #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_soccer_overlay (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cen_i      (cen_i),
        .vid_sel_i  (vid_sel_i),
        .vid_rgb_i  (src_rgb),
        .vh_blank_i (src_blank),
        .dvh_sync_i (src_sync),
        .dvh_sync_o (dvh_sync_o),
        .vid_rgb_o  (vid_rgb_o)
    );

    task automatic stop_on_mismatch(input string name, input logic [23:0] got,
                                    input logic [23:0] want);
        $display("mismatch %s: got %h, expected %h", name, got, want);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    // ======================================================================
    // reference of the previous enabled cycle and probe bookkeeping
    // ======================================================================
    assign on_video   = sel_q && sync_q[2];
    assign at_a       = on_video && (x_q == PROBE_A_X) && (y_q == PROBE_Y);
    assign at_b       = on_video && (x_q == PROBE_B_X) && (y_q == PROBE_Y);
    assign on_outline = on_video && (y_q == PM) && (x_q >= PM) && (x_q <= H_ACTIVE - PM - 1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rgb_q  <= soccer_pkg::SKY_BG;
            sync_q <= 3'b000;
            sel_q  <= 1'b0;
            x_q    <= 0;
            y_q    <= 0;
        end else begin
            if (cen_i) begin
                rgb_q  <= src_rgb;
                sync_q <= src_sync;
                sel_q  <= vid_sel_i;
                x_q    <= int'(src_x);
                y_q    <= int'(src_y);
            end
            if (at_a) begin
                a_seen <= 1'b1;
                a_lit  <= a_lit || (vid_rgb_o == ONE_RGB);
            end
            if (at_b && a_lit && (vid_rgb_o == ONE_RGB)) begin
                b_lit <= 1'b1;
            end
            line0_hits   <= line0_hits + int'(on_video && (y_q == 0));
            outline_hits <= outline_hits + int'(on_outline);
            hold_hits    <= hold_hits + int'(!cen_i);
            pass_hits    <= pass_hits + int'(!sel_q && sync_q[2]);
        end
    end

    // short enable gaps, some of them inside active video
    always_ff @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        cen_i     <= (cycle_cnt % 1013) < 1009;
        if (cycle_cnt >= LIMIT_CYCLES) begin
            stop_with_error("timeout: the score digits did not both change in time");
        end
    end

    // ======================================================================
    // checks
    // ======================================================================
    rgb_pass: assert property (@(posedge clk_i) disable iff (rst_i)
        !on_video |-> (vid_rgb_o == rgb_q))
        else stop_on_mismatch("vid_rgb_o", $sampled(vid_rgb_o), $sampled(rgb_q));
    sync_pass: assert property (@(posedge clk_i) disable iff (rst_i)
        dvh_sync_o == sync_q)
        else stop_on_mismatch("dvh_sync_o", 24'($sampled(dvh_sync_o)), 24'($sampled(sync_q)));
    rgb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        !$past(cen_i) |-> $stable(vid_rgb_o))
        else stop_on_mismatch("vid_rgb_o", $sampled(vid_rgb_o), $past(vid_rgb_o));
    sync_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        !$past(cen_i) |-> $stable(dvh_sync_o))
        else stop_on_mismatch("dvh_sync_o", 24'($sampled(dvh_sync_o)), 24'($past(dvh_sync_o)));
    sky_top: assert property (@(posedge clk_i) disable iff (rst_i)
        (on_video && (y_q == 0)) |-> (vid_rgb_o == soccer_pkg::SKY_BG))
        else stop_on_mismatch("vid_rgb_o", $sampled(vid_rgb_o), soccer_pkg::SKY_BG);
    top_outline: assert property (@(posedge clk_i) disable iff (rst_i)
        on_outline |-> (vid_rgb_o == soccer_pkg::LINE_WHITE))
        else stop_on_mismatch("vid_rgb_o", $sampled(vid_rgb_o), soccer_pkg::LINE_WHITE);
    a_first: assert property (@(posedge clk_i) disable iff (rst_i)
        (at_a && !a_seen) |-> (vid_rgb_o == ZERO_RGB))
        else stop_on_mismatch("vid_rgb_o", $sampled(vid_rgb_o), ZERO_RGB);
    a_digit: assert property (@(posedge clk_i) disable iff (rst_i)
        at_a |-> ((vid_rgb_o == ZERO_RGB) || (vid_rgb_o == ONE_RGB)))
        else stop_on_mismatch("vid_rgb_o", $sampled(vid_rgb_o), ONE_RGB);
    a_stays: assert property (@(posedge clk_i) disable iff (rst_i)
        (at_a && a_lit) |-> (vid_rgb_o == ONE_RGB))
        else stop_on_mismatch("vid_rgb_o", $sampled(vid_rgb_o), ONE_RGB);
    b_after_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (at_b && !a_lit) |-> (vid_rgb_o == ZERO_RGB))
        else stop_on_mismatch("vid_rgb_o", $sampled(vid_rgb_o), ZERO_RGB);

    initial begin
        rst_i     = 1'b1;
        vid_sel_i = 1'b0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        // passthrough first, then the overlay
        repeat (2 * FRAME_CYCLES) @(posedge clk_i);
        vid_sel_i <= 1'b1;
        wait (b_lit);
        repeat (H_TOTAL) @(posedge clk_i);
        if ((line0_hits == 0) || (outline_hits == 0) || (hold_hits == 0) || (pass_hits == 0)) begin
            stop_with_error("some checks were never reached by the stimulus");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- soccer_overlay.f
source/soccer_pkg.sv
source/raster_if.sv
source/match_if.sv
source/raster_timing.sv
source/ball_match.sv
source/pitch_render.sv
source/soccer_overlay.sv
test/video_source.sv
test/tb_soccer_overlay.sv

//--- Makefile
# Verilator build and run for the soccer overlay testbench

TOP = tb_soccer_overlay

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f soccer_overlay.f

# pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
